// File: files.f
source/lf_pkg.sv
source/fpga_conf_rx.sv
source/lo_adc.sv
source/lf_mode_mux.sv
source/lf_frontend.sv
tests/lf_frontend_checker.sv
tests/lf_frontend_tb.sv

// File: run.sh
#!/bin/sh
# Build the lf front end testbench with Verilator, run it and grade the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f files.f \
  --top-module lf_frontend_tb -o lf_frontend_sim \
  && ./obj_dir/lf_frontend_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tests/lf_frontend_tb.sv
/*
 * Directed testbench for the low-frequency front end.
 * Configures the DUT over the host link, then checks sample framing,
 * ADC clock timing, antenna modulation, passthrough and command rejection.
 */

`timescale 1ns/1ps

module lf_frontend_tb;

  import lf_pkg::*;

  // --------------------------------------------------------------------------
  // run constants
  // --------------------------------------------------------------------------

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 4;
  localparam logic [31:0] SEED = 32'd6365;
  // pck0 cycles per half period of spck
  localparam int SPI_HALF     = 3;
  localparam int NUM_SAMPLES  = 8;
  localparam int NUM_DIVS     = 4;
  localparam int NUM_TESTS    = 6;
  localparam int MAX_DIV      = 40;
  // counter may wrap through 255 after a divisor change
  localparam int WAIT_LIMIT   = 600;
  // frames per test, each frame up to two levels of the slowest adc clock
  localparam int WD_NS = NUM_TESTS * NUM_SAMPLES * NUM_DIVS * (2 * MAX_DIV + 2)
                         * CLK_PERIOD * 2;

  // dut inputs
  logic             pck0;
  logic             rst;
  logic             spck;
  logic             mosi;
  logic             ncs;
  logic [ADC_W-1:0] adc_d;
  logic             ssp_dout;
  logic             cross_lo;

  // dut outputs
  logic pwr_lo;
  logic pwr_hi;
  logic pwr_oe1;
  logic pwr_oe2;
  logic pwr_oe3;
  logic pwr_oe4;
  logic adc_clk;
  logic ssp_din;
  logic ssp_frame;
  logic ssp_clk;
  logic dbg;

  // lcg state and the divisor the DUT should hold
  logic [31:0] lcg_state;
  logic [7:0]  cur_div;

  lf_frontend #(
    .ADC_W (ADC_W)
  ) dut_i (
    .pck0      (pck0),
    .rst       (rst),
    .spck      (spck),
    .mosi      (mosi),
    .ncs       (ncs),
    .adc_d     (adc_d),
    .ssp_dout  (ssp_dout),
    .cross_lo  (cross_lo),
    .pwr_lo    (pwr_lo),
    .pwr_hi    (pwr_hi),
    .pwr_oe1   (pwr_oe1),
    .pwr_oe2   (pwr_oe2),
    .pwr_oe3   (pwr_oe3),
    .pwr_oe4   (pwr_oe4),
    .adc_clk   (adc_clk),
    .ssp_din   (ssp_din),
    .ssp_frame (ssp_frame),
    .ssp_clk   (ssp_clk),
    .dbg       (dbg)
  );

  initial
  begin
    pck0 = 1'b0;
    forever #(CLK_PERIOD / 2) pck0 = ~pck0;
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // upper half of the state has the better random bits
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {16'h0000, lcg_state[31:16]};
  endfunction

  // first pick is the minimum divisor for a full frame
  function automatic logic [7:0] pick_divisor(input int idx);
    if (idx == 0)
      return 8'd15;
    return 8'(15 + next_rand() % 26);
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected)
    begin
      $display("Fail at %0t ns: %s, got %0h expected %0h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge pck0);
  endtask

  // ssp_clk sampled a quarter period into each pck0 phase
  task automatic check_ssp_clk(input string what);
    @(negedge pck0);
    #(CLK_PERIOD / 4);
    check_eq(32'(ssp_clk), 32'd0, what);
    #(CLK_PERIOD / 2);
    check_eq(32'(ssp_clk), 32'd1, what);
    @(negedge pck0);
  endtask

  // bit-bang the top nbits of word, MSB first, mosi set up half a bit early
  task automatic send_cmd(input logic [CMD_W-1:0] word, input int nbits);
    int i;
    @(negedge pck0);
    ncs = 1'b0;
    wait_cycles(SPI_HALF);
    for (i = 0; i < nbits; i++)
    begin
      mosi = word[CMD_W-1-i];
      wait_cycles(SPI_HALF);
      spck = 1'b1;
      wait_cycles(SPI_HALF);
      spck = 1'b0;
    end
    wait_cycles(SPI_HALF);
    ncs  = 1'b1;
    mosi = 1'b0;
    // sync stages, edge detect and decode strobe
    wait_cycles(6);
  endtask

  task automatic set_divisor(input logic [7:0] div);
    lf_payload_u p;
    p.divisor = div;
    send_cmd({OP_SET_DIVISOR, 4'h0, p}, CMD_W);
    cur_div = div;
  endtask

  task automatic set_mode(input lf_mode_t m, input logic field);
    lf_payload_u p;
    p.flags.mode     = m;
    p.flags.lf_field = field;
    p.flags.rsvd     = 4'h0;
    send_cmd({OP_SET_MODE, 4'h0, p}, CMD_W);
  endtask

  // cycles until adc_clk leaves its present level, dbg checked on the way
  task automatic wait_adc_edge(output int cycles);
    logic level;
    level  = adc_clk;
    cycles = 0;
    while (adc_clk == level)
    begin
      @(negedge pck0);
      check_eq(32'(dbg), 32'(adc_clk), "dbg mirrors adc_clk");
      cycles++;
      if (cycles > WAIT_LIMIT)
        abort_run("adc_clk stopped toggling");
    end
  endtask

  // align to a transition first, then time one whole level
  task automatic measure_level(output int cycles);
    int skip;
    wait_adc_edge(skip);
    wait_adc_edge(cycles);
  endtask

  // shift in ssp_din for as long as ssp_frame stays high
  task automatic capture_frame(output logic [ADC_W-1:0] word, output int nbits);
    int guard;
    word  = '0;
    nbits = 0;
    guard = 0;
    while (!ssp_frame)
    begin
      @(negedge pck0);
      guard++;
      if (guard > 2 * WAIT_LIMIT)
        abort_run("no ssp_frame seen");
    end
    while (ssp_frame)
    begin
      word = {word[ADC_W-2:0], ssp_din};
      nbits++;
      @(negedge pck0);
    end
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic test_reset_state();
    int n;
    for (n = 0; n < 8; n++)
    begin
      check_eq(32'({pwr_lo, pwr_hi, pwr_oe1, pwr_oe2, pwr_oe3, pwr_oe4}), 32'd0,
               "pwr outputs after reset");
      check_eq(32'({ssp_frame, ssp_din, adc_clk, dbg}), 32'd0, "ssp and clock after reset");
      @(negedge pck0);
    end
    check_ssp_clk("ssp_clk in off mode");
  endtask

  task automatic test_serialise();
    int d;
    int s;
    int nbits;
    logic [ADC_W-1:0] sample;
    logic [ADC_W-1:0] got;
    set_mode(MODE_LO_ADC, 1'b0);
    for (d = 0; d < NUM_DIVS; d++)
    begin
      set_divisor(pick_divisor(d));
      for (s = 0; s < NUM_SAMPLES; s++)
      begin
        // change adc_d only between frames so the next load sees it
        while (ssp_frame)
          @(negedge pck0);
        sample = ADC_W'(next_rand());
        adc_d  = sample;
        capture_frame(got, nbits);
        check_eq(32'(nbits), 32'(ADC_W), "ssp_frame length");
        check_eq(32'(got), 32'(sample), "serialised sample");
      end
    end
  endtask

  task automatic test_adc_clock();
    int d;
    int n;
    int len;
    set_mode(MODE_LO_ADC, 1'b0);
    for (d = 0; d < NUM_DIVS; d++)
    begin
      set_divisor(pick_divisor(d));
      for (n = 0; n < 4; n++)
      begin
        measure_level(len);
        check_eq(32'(len), 32'(cur_div) + 32'd1, "adc_clk level length");
      end
    end
    check_ssp_clk("ssp_clk in adc mode");
  endtask

  task automatic test_modulation();
    int n;
    logic want_lo;
    set_divisor(8'd20);
    set_mode(MODE_LO_ADC, 1'b0);
    // tag side, the coil load follows the host bit
    for (n = 0; n < 32; n++)
    begin
      ssp_dout = 1'(next_rand());
      @(negedge pck0);
      check_eq(32'(pwr_oe3), 32'(ssp_dout), "tag mode pwr_oe3");
      check_eq(32'(pwr_lo), 32'd0, "tag mode pwr_lo");
    end
    set_mode(MODE_LO_ADC, 1'b1);
    // reader side, covers both adc_clk levels a few times
    for (n = 0; n < 4 * (int'(cur_div) + 1); n++)
    begin
      ssp_dout = 1'(next_rand());
      @(negedge pck0);
      want_lo = ~ssp_dout & ~adc_clk;
      check_eq(32'(pwr_lo), 32'(want_lo), "reader mode pwr_lo");
      check_eq(32'(pwr_oe3), 32'd0, "reader mode pwr_oe3");
    end
    ssp_dout = 1'b0;
  endtask

  task automatic test_passthru();
    int n;
    set_mode(MODE_PASSTHRU, 1'b0);
    for (n = 0; n < 32; n++)
    begin
      cross_lo = 1'(next_rand());
      ssp_dout = 1'(next_rand());
      @(negedge pck0);
      check_eq(32'(ssp_din), 32'(cross_lo), "passthrough ssp_din");
      check_eq(32'(pwr_lo), 32'(ssp_dout), "passthrough pwr_lo");
      check_eq(32'({ssp_frame, adc_clk, dbg, pwr_oe3}), 32'd0, "passthrough idle outputs");
    end
    cross_lo = 1'b0;
    ssp_dout = 1'b0;
    check_ssp_clk("ssp_clk in passthrough mode");
  endtask

  task automatic test_rejected();
    lf_payload_u p;
    int len;
    set_mode(MODE_LO_ADC, 1'b0);
    // divisor 17 leaves 4'h1 in the low nibble of the command shift register
    set_divisor(8'd17);
    measure_level(len);
    check_eq(32'(len), 32'(cur_div) + 32'd1, "adc_clk level before rejects");
    // 12 bits land behind that nibble and would decode as opcode 1 with divisor 30
    p.divisor = 8'd30;
    send_cmd({OP_SET_DIVISOR, p, 4'h0}, 12);
    measure_level(len);
    check_eq(32'(len), 32'(cur_div) + 32'd1, "divisor after short command");
    // unknown opcode, payload would read as divisor 31 or as mode off
    p.divisor = 8'h1F;
    send_cmd({4'd5, 4'h0, p}, CMD_W);
    measure_level(len);
    check_eq(32'(len), 32'(cur_div) + 32'd1, "divisor after unknown opcode");
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------

  initial
  begin
    lcg_state = SEED;
    cur_div   = 8'd0;
    rst       = 1'b1;
    spck      = 1'b0;
    mosi      = 1'b0;
    ncs       = 1'b1;
    adc_d     = '0;
    ssp_dout  = 1'b0;
    cross_lo  = 1'b0;
    repeat (RESET_CYCLES) @(negedge pck0);
    rst = 1'b0;
    test_reset_state();
    test_serialise();
    test_adc_clock();
    test_modulation();
    test_passthru();
    test_rejected();
    $display("Test passed");
    $finish;
  end

  initial
  begin
    #(WD_NS);
    $display("Error: simulation timed out after %0d ns", WD_NS);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tests/lf_frontend_checker.sv
/*
 * Pin-level assertions for the low-frequency front end.
 * Bound into lf_frontend, so it also sees the decoded mode.
 */

`timescale 1ns/1ps

module lf_frontend_checker (
  input logic             pck0,
  input logic             rst,
  input lf_pkg::lf_mode_t mode,
  input logic             pwr_lo,
  input logic             pwr_hi,
  input logic             pwr_oe1,
  input logic             pwr_oe2,
  input logic             pwr_oe3,
  input logic             pwr_oe4,
  input logic             adc_clk,
  input logic             ssp_frame
);

  import lf_pkg::*;

  // sample window sits inside the high adc_clk half
  frame_in_clk_high: assert property (@(posedge pck0) disable iff (rst)
    ssp_frame |-> adc_clk)
    else $error("ssp_frame high while adc_clk low");

  // tag and reader drivers exclude each other
  lo_oe3_exclusive: assert property (@(posedge pck0) disable iff (rst)
    !(pwr_lo && pwr_oe3))
    else $error("pwr_lo and pwr_oe3 both high");

  unused_drivers_low: assert property (@(posedge pck0) disable iff (rst)
    !(pwr_hi || pwr_oe1 || pwr_oe2 || pwr_oe4))
    else $error("unused antenna driver went high");

  off_mode_quiet: assert property (@(posedge pck0) disable iff (rst)
    (mode == MODE_OFF) |-> (!adc_clk && !ssp_frame))
    else $error("adc_clk or ssp_frame active in off mode");

endmodule

bind lf_frontend lf_frontend_checker checker_i (
  .pck0      (pck0),
  .rst       (rst),
  .mode      (mode),
  .pwr_lo    (pwr_lo),
  .pwr_hi    (pwr_hi),
  .pwr_oe1   (pwr_oe1),
  .pwr_oe2   (pwr_oe2),
  .pwr_oe3   (pwr_oe3),
  .pwr_oe4   (pwr_oe4),
  .adc_clk   (adc_clk),
  .ssp_frame (ssp_frame)
);

// File: source/lf_frontend.sv
/*
 * Top level of the low-frequency reader front end.
 * Connects the host configuration receiver, the ADC-mode block and the
 * mode selector. ADC_W sets the sample width of the ADC block.
 */

`timescale 1ns/1ps

module lf_frontend #(
  parameter int ADC_W = lf_pkg::ADC_W
) (
  input  logic             pck0,
  input  logic             rst,
  // host configuration link
  input  logic             spck,
  input  logic             mosi,
  input  logic             ncs,
  // analogue side and host data
  input  logic [ADC_W-1:0] adc_d,
  input  logic             ssp_dout,
  input  logic             cross_lo,
  // antenna drivers
  output logic             pwr_lo,
  output logic             pwr_hi,
  output logic             pwr_oe1,
  output logic             pwr_oe2,
  output logic             pwr_oe3,
  output logic             pwr_oe4,
  // adc clock and ssp to the host
  output logic             adc_clk,
  output logic             ssp_din,
  output logic             ssp_frame,
  output logic             ssp_clk,
  output logic             dbg
);

  import lf_pkg::*;

  // configuration
  logic [7:0] divisor;
  logic       lf_field;
  lf_mode_t   mode;

  // adc block outputs, before mode routing
  logic adc_clk_lo;
  logic ssp_din_lo;
  logic ssp_frame_lo;
  logic pwr_lo_lo;
  logic pwr_oe3_lo;

  // --------------------------------------------------------------------------
  // instances
  // --------------------------------------------------------------------------

  fpga_conf_rx conf_rx_i (
    .pck0     (pck0),
    .rst      (rst),
    .spck     (spck),
    .mosi     (mosi),
    .ncs      (ncs),
    .divisor  (divisor),
    .lf_field (lf_field),
    .mode     (mode)
  );

  lo_adc #(
    .ADC_W (ADC_W)
  ) lo_adc_i (
    .pck0      (pck0),
    .rst       (rst),
    .adc_d     (adc_d),
    .ssp_dout  (ssp_dout),
    .divisor   (divisor),
    .lf_field  (lf_field),
    .adc_clk   (adc_clk_lo),
    .ssp_din   (ssp_din_lo),
    .ssp_frame (ssp_frame_lo),
    .pwr_lo    (pwr_lo_lo),
    .pwr_oe3   (pwr_oe3_lo)
  );

  lf_mode_mux mode_mux_i (
    .pck0         (pck0),
    .mode         (mode),
    .adc_clk_lo   (adc_clk_lo),
    .ssp_din_lo   (ssp_din_lo),
    .ssp_frame_lo (ssp_frame_lo),
    .pwr_lo_lo    (pwr_lo_lo),
    .pwr_oe3_lo   (pwr_oe3_lo),
    .ssp_dout     (ssp_dout),
    .cross_lo     (cross_lo),
    .pwr_lo       (pwr_lo),
    .pwr_hi       (pwr_hi),
    .pwr_oe1      (pwr_oe1),
    .pwr_oe2      (pwr_oe2),
    .pwr_oe3      (pwr_oe3),
    .pwr_oe4      (pwr_oe4),
    .adc_clk      (adc_clk),
    .ssp_din      (ssp_din),
    .ssp_frame    (ssp_frame),
    .ssp_clk      (ssp_clk),
    .dbg          (dbg)
  );

endmodule

// File: source/lf_mode_mux.sv
/*
 * Major mode selector. Routes the ADC-mode outputs, the bit-bang
 * passthrough or the all-low off state to the front-end pins.
 */

`timescale 1ns/1ps

module lf_mode_mux (
  input  logic             pck0,
  input  lf_pkg::lf_mode_t mode,
  input  logic             adc_clk_lo,
  input  logic             ssp_din_lo,
  input  logic             ssp_frame_lo,
  input  logic             pwr_lo_lo,
  input  logic             pwr_oe3_lo,
  input  logic             ssp_dout,
  input  logic             cross_lo,
  output logic             pwr_lo,
  output logic             pwr_hi,
  output logic             pwr_oe1,
  output logic             pwr_oe2,
  output logic             pwr_oe3,
  output logic             pwr_oe4,
  output logic             adc_clk,
  output logic             ssp_din,
  output logic             ssp_frame,
  output logic             ssp_clk,
  output logic             dbg
);

  import lf_pkg::*;

  // --------------------------------------------------------------------------
  // mode decode
  // --------------------------------------------------------------------------

  always_comb
  begin
    // off and undefined codes keep everything low
    pwr_lo    = 1'b0;
    pwr_oe3   = 1'b0;
    adc_clk   = 1'b0;
    ssp_din   = 1'b0;
    ssp_frame = 1'b0;
    case (mode)
      MODE_LO_ADC:
      begin
        pwr_lo    = pwr_lo_lo;
        pwr_oe3   = pwr_oe3_lo;
        adc_clk   = adc_clk_lo;
        ssp_din   = ssp_din_lo;
        ssp_frame = ssp_frame_lo;
      end
      MODE_PASSTHRU:
      begin
        // host bit-bangs the antenna and reads the comparator
        ssp_din = cross_lo;
        pwr_lo  = ssp_dout;
      end
      default: ;
    endcase
  end

  // unused drivers in every lf mode
  assign pwr_hi  = 1'b0;
  assign pwr_oe1 = 1'b0;
  assign pwr_oe2 = 1'b0;
  assign pwr_oe4 = 1'b0;

  // ssp clock is always the master clock
  assign ssp_clk = pck0;

  // debug pin mirrors the routed adc clock
  assign dbg = adc_clk;

endmodule

// File: source/lo_adc.sv
/*
 * Low-frequency ADC mode. Divides pck0 down to the ADC clock, serialises
 * each sample to the host in an SSP frame and drives the antenna either
 * as tag load modulation or as reader field modulation.
 */

`timescale 1ns/1ps

module lo_adc #(
  parameter int ADC_W = lf_pkg::ADC_W
) (
  input  logic             pck0,
  input  logic             rst,
  input  logic [ADC_W-1:0] adc_d,
  input  logic             ssp_dout,
  input  logic [7:0]       divisor,
  input  logic             lf_field,
  output logic             adc_clk,
  output logic             ssp_din,
  output logic             ssp_frame,
  output logic             pwr_lo,
  output logic             pwr_oe3
);

  // counts within the low half of clk_state
  // sample is loaded one cycle before the frame opens
  localparam logic [7:0] LOAD_CNT    = 8'(ADC_W - 1);
  localparam logic [7:0] FRAME_FIRST = 8'(ADC_W);
  localparam logic [7:0] FRAME_LAST  = 8'(2 * ADC_W - 1);

  logic [7:0]       pck_cnt;
  logic             clk_state;
  logic [ADC_W-1:0] shift_q;
  logic             tag_mod;
  logic             reader_mod;

  // --------------------------------------------------------------------------
  // clock divider
  // --------------------------------------------------------------------------

  // count 0..divisor, clk_state flips on every restart
  // each half period therefore lasts divisor+1 cycles
  always_ff @(posedge pck0)
  begin
    if (rst)
    begin
      pck_cnt   <= 8'd0;
      clk_state <= 1'b0;
    end
    else if (pck_cnt == divisor)
    begin
      pck_cnt   <= 8'd0;
      clk_state <= ~clk_state;
    end
    else
    begin
      pck_cnt <= pck_cnt + 8'd1;
    end
  end

  // adc clock runs out of phase with the antenna driver
  assign adc_clk = ~clk_state;

  // --------------------------------------------------------------------------
  // sample serialiser
  // --------------------------------------------------------------------------

  // load while the adc clock is high, then shift out msb first
  // zeros fill in behind the sample
  always_ff @(posedge pck0)
  begin
    if (rst)
      shift_q <= '0;
    else if (pck_cnt == LOAD_CNT && !clk_state)
      shift_q <= adc_d;
    else
      shift_q <= {shift_q[ADC_W-2:0], 1'b0};
  end

  // data and frame are both masked during the high clk_state half
  assign ssp_din   = shift_q[ADC_W-1] & ~clk_state;
  assign ssp_frame = (pck_cnt >= FRAME_FIRST) && (pck_cnt <= FRAME_LAST) && !clk_state;

  // --------------------------------------------------------------------------
  // antenna modulation
  // --------------------------------------------------------------------------

  // tag mode loads the coil directly from the host bit
  assign tag_mod    = ssp_dout & ~lf_field;

  // reader mode drives the field in the high half, host bit low gaps it
  assign reader_mod = ~ssp_dout & lf_field & clk_state;

  assign pwr_oe3 = tag_mod;
  assign pwr_lo  = reader_mod;

endmodule

// File: source/fpga_conf_rx.sv
/*
 * Host configuration receiver. Brings the slow SPI-style link into pck0,
 * assembles 16-bit commands MSB first and holds the divisor and mode.
 * A command is accepted only if exactly 16 bits arrived while ncs was low.
 */

`timescale 1ns/1ps

module fpga_conf_rx (
  input  logic             pck0,
  input  logic             rst,
  input  logic             spck,
  input  logic             mosi,
  input  logic             ncs,
  output logic [7:0]       divisor,
  output logic             lf_field,
  output lf_pkg::lf_mode_t mode
);

  import lf_pkg::*;

  // two-flop synchronisers, bit 1 is the usable one
  logic [1:0] spck_sync;
  logic [1:0] mosi_sync;
  logic [1:0] ncs_sync;

  // previous synced levels for edge detection
  logic spck_q;
  logic ncs_q;

  logic             spck_rise;
  logic             ncs_fall;
  logic             ncs_rise;
  logic [CMD_W-1:0] cmd_sr;
  logic [4:0]       bit_cnt;
  logic             cmd_stb;
  lf_payload_u      payload;

  // --------------------------------------------------------------------------
  // synchronise and detect edges
  // --------------------------------------------------------------------------

  always_ff @(posedge pck0)
  begin
    if (rst)
    begin
      spck_sync <= 2'b00;
      mosi_sync <= 2'b00;
      // link idles with ncs high
      ncs_sync  <= 2'b11;
      spck_q    <= 1'b0;
      ncs_q     <= 1'b1;
    end
    else
    begin
      spck_sync <= {spck_sync[0], spck};
      mosi_sync <= {mosi_sync[0], mosi};
      ncs_sync  <= {ncs_sync[0], ncs};
      spck_q    <= spck_sync[1];
      ncs_q     <= ncs_sync[1];
    end
  end

  assign spck_rise = spck_sync[1] & ~spck_q;
  assign ncs_fall  = ~ncs_sync[1] & ncs_q;
  assign ncs_rise  = ncs_sync[1] & ~ncs_q;

  // --------------------------------------------------------------------------
  // command assembly
  // --------------------------------------------------------------------------

  always_ff @(posedge pck0)
  begin
    if (rst)
    begin
      bit_cnt <= 5'd0;
      cmd_stb <= 1'b0;
    end
    else
    begin
      // count restarts with each frame, saturates so long frames never match
      if (ncs_fall)
        bit_cnt <= 5'd0;
      else if (spck_rise && !ncs_sync[1] && bit_cnt != 5'd31)
        bit_cnt <= bit_cnt + 5'd1;
      // registered strobe, the decode lands one cycle later
      cmd_stb <= ncs_rise && (bit_cnt == 5'(CMD_W));
    end
  end

  // command shift register, MSB first
  always_ff @(posedge pck0)
  begin
    if (spck_rise && !ncs_sync[1])
      cmd_sr <= {cmd_sr[CMD_W-2:0], mosi_sync[1]};
  end

  assign payload = cmd_sr[7:0];

  // --------------------------------------------------------------------------
  // configuration registers
  // --------------------------------------------------------------------------

  always_ff @(posedge pck0)
  begin
    if (rst)
    begin
      divisor  <= 8'd0;
      lf_field <= 1'b0;
      mode     <= MODE_OFF;
    end
    else if (cmd_stb)
    begin
      case (cmd_sr[CMD_W-1 -: 4])
        OP_SET_DIVISOR: divisor <= payload.divisor;
        OP_SET_MODE:
        begin
          mode     <= payload.flags.mode;
          lf_field <= payload.flags.lf_field;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: source/lf_pkg.sv
/*
 * Shared definitions for the low-frequency front end.
 * Holds mode codes, host command opcodes, widths and the payload union.
 * Design and testbench files import this package where needed.
 */

package lf_pkg;

  // --------------------------------------------------------------------------
  // widths
  // --------------------------------------------------------------------------

  // default adc sample width
  localparam int ADC_W = 8;

  // host command word
  // [15:12] opcode, [11:8] reserved, [7:0] payload
  localparam int CMD_W = 16;

  // --------------------------------------------------------------------------
  // host command opcodes
  // --------------------------------------------------------------------------

  // any other opcode is ignored by the receiver
  localparam logic [3:0] OP_SET_DIVISOR = 4'd1;
  localparam logic [3:0] OP_SET_MODE    = 4'd2;

  // --------------------------------------------------------------------------
  // major modes
  // --------------------------------------------------------------------------

  typedef logic [2:0] lf_mode_t;

  // codes 3..7 are treated as off
  localparam lf_mode_t MODE_OFF      = 3'd0;
  localparam lf_mode_t MODE_LO_ADC   = 3'd1;
  localparam lf_mode_t MODE_PASSTHRU = 3'd2;

  // payload byte, read as a divisor or as mode flags depending on opcode
  typedef union packed {
    logic [7:0] divisor;
    struct packed {
      lf_mode_t   mode;
      logic       lf_field;
      logic [3:0] rsvd;
    } flags;
  } lf_payload_u;

endpackage
